//--- verilog/aud_pkg.sv
`default_nettype none

package aud_pkg;

    localparam int AUD_W  = 16;  // sample bits
    localparam int ADDR_W = 20;  // sram word address bits

    typedef logic signed [AUD_W-1:0] sample_t;
    typedef logic [ADDR_W-1:0]       addr_t;

    // fast step, value n moves n+1 words per sample
    typedef logic [2:0] step_t;

    // log2 of slow factor, 0 = slow mode off
    typedef logic [1:0] slow_t;

    // output sample index inside one slow period
    typedef logic [2:0] phase_t;

    typedef enum logic {
        INTERP_HOLD   = 1'b0,
        INTERP_LINEAR = 1'b1
    } interp_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2,
        ST_STOP  = 2'd3
    } play_state_t;

endpackage

`default_nettype wire

//--- verilog/play_if.sv
`timescale 1ns/1ps
`default_nettype none

interface play_if import aud_pkg::*; ();

    logic   tick;          // one sample requested
    logic   load;          // track restart
    logic   run;           // state is ST_PLAY
    phase_t phase;         // phase at the tick
    logic   fetch_new;     // tick opens a new source word
    logic   done;          // last sample of the track
    logic   reverse_mode;

    modport ctrl   (output tick, load, run, input done);
    modport agen   (input tick, load, run,
                    output phase, fetch_new, done, reverse_mode);
    modport interp (input tick, load, phase, fetch_new, reverse_mode);

endinterface

`default_nettype wire

//--- verilog/play_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module play_ctrl import aud_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_pause,
    input  logic i_stop,
    input  logic i_daclrck,
    output logic o_player_en,
    input  logic i_player_ack,
    play_if.ctrl bus
);

    logic [SYNC_STAGES-1:0] sync_r;
    logic                   lrck_d;     // previous synced level
    logic                   fall_r;     // registered falling edge
    logic                   en_r;
    logic                   leave_play;
    play_state_t            state_r;
    play_state_t            state_nxt;

    // daclrck comes from another clock, resync before edge detect
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_r <= '0;
            lrck_d <= 1'b0;
            fall_r <= 1'b0;
        end else begin
            sync_r[0] <= i_daclrck;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_r[i] <= sync_r[i-1];
            end
            lrck_d <= sync_r[SYNC_STAGES-1];
            fall_r <= lrck_d & ~sync_r[SYNC_STAGES-1];
        end
    end

    // no new sample while a pause or stop is being taken
    assign bus.tick = fall_r && (state_r == ST_PLAY) && !i_stop && !i_pause;
    assign bus.load = (state_r == ST_IDLE) && i_start;
    assign bus.run  = (state_r == ST_PLAY);

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            ST_IDLE: begin
                if (i_start) begin
                    state_nxt = ST_PLAY;
                end
            end
            ST_PLAY: begin
                if (i_stop) begin
                    state_nxt = ST_STOP;
                end else if (bus.done) begin
                    state_nxt = ST_IDLE;   // track finished
                end else if (i_pause) begin
                    state_nxt = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                if (i_start) begin
                    state_nxt = ST_PLAY;   // resume at held address
                end else if (i_stop) begin
                    state_nxt = ST_STOP;
                end
            end
            ST_STOP: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= ST_IDLE;
        end else begin
            state_r <= state_nxt;
        end
    end

    // the done tick still raises enable for the final sample
    assign leave_play = (state_r == ST_PLAY) && (state_nxt != ST_PLAY);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            en_r <= 1'b0;
        end else if (bus.tick) begin
            en_r <= 1'b1;      // unacked sample just gets overwritten
        end else if (i_player_ack || leave_play) begin
            en_r <= 1'b0;
        end
    end

    assign o_player_en = en_r;

endmodule

`default_nettype wire

//--- verilog/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen import aud_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  step_t   i_step,
    input  slow_t   i_slow,
    input  interp_t i_interp,
    input  logic    i_reverse,
    input  addr_t   i_last_addr,
    output addr_t   o_sram_addr,
    play_if.agen    bus
);

    addr_t         addr_r;
    addr_t         addr_nxt;
    phase_t        phase_r;
    phase_t        phase_nxt;
    phase_t        last_ph;
    step_t         step_r;
    slow_t         slow_r;
    interp_t       interp_r;
    logic          rev_r;
    logic          slow_on;
    logic          phase_last;
    logic          step_now;     // slow mode moves the address on this tick
    logic          at_end;
    logic [ADDR_W:0] adv;
    logic [ADDR_W:0] fwd_sum;    // one extra bit, no wrap at the top
    logic          past_end;

    assign slow_on    = (slow_r != 2'd0);
    assign last_ph    = phase_t'((4'd1 << slow_r) - 4'd1);
    assign phase_last = (phase_r == last_ph);

    // hold moves on the last phase, linear on phase 0
    assign step_now = (interp_r == INTERP_LINEAR) ? (phase_r == '0) : phase_last;

    assign adv      = slow_on ? (ADDR_W+1)'(1) : (ADDR_W+1)'(step_r) + (ADDR_W+1)'(1);
    assign fwd_sum  = {1'b0, addr_r} + adv;
    assign past_end = (fwd_sum > {1'b0, i_last_addr});

    always_comb begin
        addr_nxt  = addr_r;
        phase_nxt = '0;
        at_end    = 1'b0;
        if (rev_r) begin
            if (addr_r == '0) begin
                at_end = 1'b1;   // address 0 is the last reverse sample
            end else begin
                addr_nxt = addr_r - addr_t'(1);
            end
        end else if (slow_on) begin
            phase_nxt = phase_last ? '0 : phase_r + phase_t'(1);
            if (step_now) begin
                if (past_end) begin
                    at_end = 1'b1;
                end else begin
                    addr_nxt = fwd_sum[ADDR_W-1:0];
                end
            end
        end else begin
            if (past_end) begin
                at_end = 1'b1;   // address holds
            end else begin
                addr_nxt = fwd_sum[ADDR_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_r   <= '0;
            phase_r  <= '0;
            step_r   <= '0;
            slow_r   <= '0;
            interp_r <= INTERP_HOLD;
            rev_r    <= 1'b0;
        end else if (bus.load) begin
            addr_r   <= i_reverse ? i_last_addr : '0;
            phase_r  <= '0;
            step_r   <= i_step;
            slow_r   <= i_slow;
            interp_r <= i_interp;
            rev_r    <= i_reverse;
        end else if (bus.tick) begin
            addr_r   <= addr_nxt;
            phase_r  <= phase_nxt;
            step_r   <= i_step;
            slow_r   <= i_slow;
            interp_r <= i_interp;
            rev_r    <= i_reverse;
        end
    end

    assign o_sram_addr      = addr_r;
    assign bus.phase        = phase_r;
    assign bus.fetch_new    = rev_r || !slow_on || (phase_r == '0);
    assign bus.done         = bus.tick && at_end;
    assign bus.reverse_mode = bus.run && rev_r;

endmodule

`default_nettype wire

//--- verilog/interp.sv
`timescale 1ns/1ps
`default_nettype none

module interp import aud_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  sample_t i_sram_data,
    input  interp_t i_interp,
    input  slow_t   i_slow,
    output sample_t o_dac_data,
    play_if.interp  bus
);

    sample_t               dac_r;
    sample_t               old_r;      // word at the start of the slow period
    logic                  lin;
    logic signed [4:0]     w_full;     // 2^slow
    logic signed [4:0]     w_new;
    logic signed [4:0]     w_old;
    logic signed [AUD_W+4:0] mix_sum;
    logic signed [AUD_W+4:0] mix_shr;
    sample_t               dac_nxt;

    // weighted average only between fetches
    assign lin = (i_interp == INTERP_LINEAR) && (i_slow != 2'd0) &&
                 !bus.reverse_mode && !bus.fetch_new;

    assign w_full = 5'sd1 << i_slow;
    assign w_new  = $signed({2'b00, bus.phase});
    assign w_old  = w_full - w_new;

    // old*(2^s-k) + new*k arithmetically shifted by s
    assign mix_sum = old_r * w_old + i_sram_data * w_new;
    assign mix_shr = mix_sum >>> i_slow;

    always_comb begin
        if (lin) begin
            dac_nxt = mix_shr[AUD_W-1:0];   // average never leaves range
        end else begin
            dac_nxt = i_sram_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dac_r <= '0;
        end else if (bus.tick) begin
            dac_r <= dac_nxt;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            old_r <= '0;
        end else if (bus.load) begin
            old_r <= '0;
        end else if (bus.tick && bus.fetch_new) begin
            old_r <= i_sram_data;
        end
    end

    assign o_dac_data = dac_r;

endmodule

`default_nettype wire

//--- verilog/aud_dsp_top.sv
`timescale 1ns/1ps
`default_nettype none

module aud_dsp_top import aud_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_start,
    input  logic    i_pause,
    input  logic    i_stop,
    input  logic    i_daclrck,
    input  step_t   i_step,
    input  slow_t   i_slow,
    input  interp_t i_interp,
    input  logic    i_reverse,
    input  addr_t   i_last_addr,
    input  sample_t i_sram_data,
    input  logic    i_player_ack,
    output sample_t o_dac_data,
    output addr_t   o_sram_addr,
    output logic    o_player_en
);

    play_if u_bus ();

    // lrclk edge, fsm, player handshake
    play_ctrl #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_daclrck    (i_daclrck),
        .o_player_en  (o_player_en),
        .i_player_ack (i_player_ack),
        .bus          (u_bus.ctrl)
    );

    addr_gen u_agen (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_step      (i_step),
        .i_slow      (i_slow),
        .i_interp    (i_interp),
        .i_reverse   (i_reverse),
        .i_last_addr (i_last_addr),
        .o_sram_addr (o_sram_addr),
        .bus         (u_bus.agen)
    );

    // sram data is combinational for the current address
    interp u_interp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sram_data (i_sram_data),
        .i_interp    (i_interp),
        .i_slow      (i_slow),
        .o_dac_data  (o_dac_data),
        .bus         (u_bus.interp)
    );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_NS    = 20,  // 40 ns period
    parameter int RST_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_NS) o_clk = ~o_clk;
    end

    // release a little after the edge, like every other input
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #2;
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/tb_aud_dsp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aud_dsp import aud_pkg::*; ();

    localparam int EN_TIMEOUT  = 200;  // cycles, ticks come every 32
    localparam int QUIET_CYCLES = 100;

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    pause;
    logic    stop;
    logic    daclrck;
    step_t   step;
    slow_t   slow;
    interp_t interp_sel;
    logic    reverse;
    addr_t   last_addr;
    sample_t sram_data;
    logic    player_ack;
    sample_t dac_data;
    addr_t   sram_addr;
    logic    player_en;

    logic [31:0] rng_state;
    sample_t     exp_data[$];   // expected samples of the current track
    addr_t       exp_addr[$];   // o_sram_addr after each sample

    tb_clk_gen #(.HALF_NS(20), .RST_CYCLES(5)) u_clk (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    aud_dsp_top #(.SYNC_STAGES(2)) dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_pause      (pause),
        .i_stop       (stop),
        .i_daclrck    (daclrck),
        .i_step       (step),
        .i_slow       (slow),
        .i_interp     (interp_sel),
        .i_reverse    (reverse),
        .i_last_addr  (last_addr),
        .i_sram_data  (sram_data),
        .i_player_ack (player_ack),
        .o_dac_data   (dac_data),
        .o_sram_addr  (sram_addr),
        .o_player_en  (player_en)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // fill pattern hashes the full address
    function automatic sample_t sram_word(input addr_t a);
        logic [31:0] h;
        h = lcg_next(32'd39138 ^ {12'd0, a});
        h = lcg_next(h ^ {a, 12'd0});
        return sample_t'(h[31:16]);
    endfunction

    always_comb sram_data = sram_word(sram_addr);  // async sram

    // left/right clock, toggles every 16 cycles
    initial begin
        daclrck = 1'b1;
        forever begin
            repeat (16) @(posedge clk);
            #2;
            daclrck = ~daclrck;
        end
    end

    task automatic rand_range(input int lo, input int hi, output int v);
        int tmp;
        rng_state = lcg_next(rng_state);
        tmp = int'(rng_state[30:16]);
        v = lo + tmp % (hi - lo + 1);
    endtask

    // weighted average of neighbours, floor shift
    function automatic sample_t lin_mix(input sample_t o, input sample_t n,
                                        input int k, input int s);
        int acc;
        acc = int'(o) * ((1 << s) - k) + int'(n) * k;
        return sample_t'(acc >>> s);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_en(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;   // drive and sample point
    endtask

    task automatic pulse(ref logic sig);
        sig = 1'b1;
        step_cycle();
        sig = 1'b0;
    endtask

    task automatic no_enable(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            step_cycle();
            check_en("o_player_en", player_en, 1'b0);
        end
    endtask

    task automatic set_track(input logic rev, input slow_t s, input interp_t im,
                             input step_t st, input addr_t last);
        reverse    = rev;
        slow       = s;
        interp_sel = im;
        step       = st;
        last_addr  = last;
    endtask

    // expected sequence straight from the playback rules
    task automatic build_model();
        int a;
        int last;
        int n;
        int adv;
        exp_data.delete();
        exp_addr.delete();
        last = int'(last_addr);
        n    = 1 << slow;
        adv  = int'(step) + 1;
        if (reverse) begin
            for (a = last; a >= 0; a--) begin
                exp_data.push_back(sram_word(addr_t'(a)));
                exp_addr.push_back(addr_t'((a > 0) ? a - 1 : 0));
            end
        end else if (slow == 2'd0) begin
            a = 0;
            while (a <= last) begin
                exp_data.push_back(sram_word(addr_t'(a)));
                if (a + adv > last) begin
                    exp_addr.push_back(addr_t'(a));   // address holds at the end
                    break;
                end
                a = a + adv;
                exp_addr.push_back(addr_t'(a));
            end
        end else if (interp_sel == INTERP_HOLD) begin
            for (a = 0; a <= last; a++) begin
                for (int k = 0; k < n; k++) begin
                    exp_data.push_back(sram_word(addr_t'(a)));
                    exp_addr.push_back(addr_t'((k == n - 1 && a < last) ? a + 1 : a));
                end
            end
        end else begin
            for (a = 0; a < last; a++) begin
                exp_data.push_back(sram_word(addr_t'(a)));
                exp_addr.push_back(addr_t'(a + 1));
                for (int k = 1; k < n; k++) begin
                    exp_data.push_back(lin_mix(sram_word(addr_t'(a)),
                                               sram_word(addr_t'(a + 1)), k, slow));
                    exp_addr.push_back(addr_t'(a + 1));
                end
            end
            exp_data.push_back(sram_word(addr_t'(last)));
            exp_addr.push_back(addr_t'(last));
        end
    endtask

    task automatic receive_sample(input sample_t exp_d, input addr_t exp_a);
        int cnt;
        cnt = 0;
        while (player_en !== 1'b1) begin
            step_cycle();
            cnt++;
            if (cnt > EN_TIMEOUT) begin
                abort_run($sformatf("timeout at %0t: no o_player_en within %0d cycles",
                                    $time, EN_TIMEOUT));
            end
        end
        check_sample("o_dac_data", dac_data, exp_d);
        check_addr("o_sram_addr", sram_addr, exp_a);
        step_cycle();
        step_cycle();
        pulse(player_ack);
        check_en("o_player_en", player_en, 1'b0);   // cleared after ack
    endtask

    task automatic play_range(input int first, input int last_idx);
        for (int i = first; i < last_idx; i++) begin
            receive_sample(exp_data[i], exp_addr[i]);
        end
    endtask

    task automatic run_track();
        build_model();
        step_cycle();
        pulse(start);
        play_range(0, exp_data.size());
        no_enable(QUIET_CYCLES);   // track over, fsm back in idle
    endtask

    initial begin
        int r_step;
        int r_last;
        int r_slow;
        int cnt;
        rng_state  = 32'd39138;
        start      = 1'b0;
        pause      = 1'b0;
        stop       = 1'b0;
        player_ack = 1'b0;
        set_track(1'b0, 2'd0, INTERP_HOLD, 3'd0, addr_t'(0));

        cnt = 0;
        while (rst_n !== 1'b1) begin
            step_cycle();
            cnt++;
            if (cnt > 20) begin
                abort_run("reset was never released");
            end
        end

        // reset values, nothing happens without start
        check_sample("o_dac_data", dac_data, sample_t'(0));
        check_addr("o_sram_addr", sram_addr, addr_t'(0));
        no_enable(QUIET_CYCLES);

        for (int t = 0; t < 3; t++) begin   // fast play
            rand_range(0, 7, r_step);
            rand_range(20, 60, r_last);
            set_track(1'b0, 2'd0, INTERP_HOLD, step_t'(r_step), addr_t'(r_last));
            run_track();
        end

        for (int s = 1; s <= 3; s++) begin   // slow hold
            rand_range(20, 60, r_last);
            set_track(1'b0, slow_t'(s), INTERP_HOLD, 3'd0, addr_t'(r_last));
            run_track();
        end

        for (int s = 1; s <= 3; s++) begin   // slow linear
            rand_range(20, 60, r_last);
            set_track(1'b0, slow_t'(s), INTERP_LINEAR, 3'd0, addr_t'(r_last));
            run_track();
        end

        rand_range(20, 60, r_last);
        set_track(1'b1, 2'd0, INTERP_HOLD, 3'd0, addr_t'(r_last));
        run_track();
        rand_range(20, 60, r_last);
        rand_range(1, 3, r_slow);
        // reverse wins over slow linear
        set_track(1'b1, slow_t'(r_slow), INTERP_LINEAR, 3'd5, addr_t'(r_last));
        run_track();

        // pause mid track, resume at the next sample
        rand_range(0, 2, r_step);
        rand_range(20, 60, r_last);
        set_track(1'b0, 2'd0, INTERP_HOLD, step_t'(r_step), addr_t'(r_last));
        build_model();
        step_cycle();
        pulse(start);
        play_range(0, 5);
        pulse(pause);
        no_enable(QUIET_CYCLES);
        pulse(start);
        play_range(5, exp_data.size());
        no_enable(QUIET_CYCLES);

        // stop then start plays again from the first sample
        step_cycle();
        pulse(start);
        play_range(0, 4);
        pulse(stop);
        no_enable(QUIET_CYCLES);
        run_track();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/aud_pkg.sv
verilog/play_if.sv
verilog/play_ctrl.sv
verilog/addr_gen.sv
verilog/interp.sv
verilog/aud_dsp_top.sv
tb/tb_clk_gen.sv
tb/tb_aud_dsp.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_aud_dsp -f list.f -o sim_aud_dsp

out=$(./obj_dir/sim_aud_dsp || true)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
